// File: logic/frame_pkg.sv
package frame_pkg;

	//////////////////////////////
	// frame field types
	//////////////////////////////

	typedef logic [7:0] byte_t;
	typedef logic [15:0] crc_t;
	typedef logic signed [31:0] setpoint_t;
	typedef logic [7:0] motor_id_t;

	//////////////////////////////
	// frame layout
	//////////////////////////////

	// magic number goes out high byte first
	localparam int MAGIC_LENGTH = 4;
	localparam logic [31:0] STATUS_REQUEST_MAGIC = 32'h1CE1CEBB;
	localparam logic [31:0] SETPOINT_MAGIC = 32'hD0D0D0D0;

	// magic, id, crc
	localparam int STATUS_REQUEST_LENGTH = 7;
	// magic, id, setpoint, crc
	localparam int SETPOINT_LENGTH = 11;
	localparam int MAX_FRAME_LENGTH = 11;
	// wide enough to hold a full frame length
	localparam int INDEX_WIDTH = $clog2(MAX_FRAME_LENGTH + 1);

	// x^16 + x^15 + x^2 + 1, msb first, no reflection, no final xor
	localparam crc_t CRC_POLY = 16'h8005;
	localparam crc_t CRC_INIT = 16'hFFFF;

	// quiet line between two frames
	localparam int GAP_CYCLES = 64;
	localparam int GAP_WIDTH = $clog2(GAP_CYCLES);

endpackage

// File: logic/uart_pkg.sv
package uart_pkg;

	//////////////////////////////
	// 8N1 character timing
	//////////////////////////////

	localparam int CLKS_PER_BIT = 16;
	// start bit, 8 data bits, stop bit
	localparam int BITS_PER_CHAR = 10;

	// counter widths for the serializer
	localparam int BIT_TIMER_WIDTH = $clog2(CLKS_PER_BIT);
	localparam int BIT_INDEX_WIDTH = $clog2(BITS_PER_CHAR);

endpackage

// File: logic/crc16_engine.sv
module crc16_engine (
	input  logic CLK,
	input  logic reset,
	input  logic crc_clear,
	input  logic crc_valid,
	input  frame_pkg::byte_t crc_byte,
	output frame_pkg::crc_t crc
);

	frame_pkg::crc_t crc_next;

	// fold one byte into the register, msb first
	function automatic frame_pkg::crc_t crc_fold(
		input frame_pkg::crc_t crc_in,
		input frame_pkg::byte_t data
	);
		frame_pkg::crc_t c;
		logic feedback;
		c = crc_in;
		for (int i = 7; i >= 0; i--) begin
			feedback = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (feedback) begin
				c = c ^ frame_pkg::CRC_POLY;
			end
		end
		return c;
	endfunction

	always_comb begin
		crc_next = crc_fold(crc, crc_byte);
	end

	// clear wins over a byte in the same cycle
	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			crc <= frame_pkg::CRC_INIT;
		end else if (crc_clear) begin
			crc <= frame_pkg::CRC_INIT;
		end else if (crc_valid) begin
			crc <= crc_next;
		end
	end

endmodule

// File: logic/uart_tx.sv
module uart_tx (
	input  logic CLK,
	input  logic reset,
	input  logic tx_start,
	input  frame_pkg::byte_t tx_byte,
	output logic tx_o,
	output logic tx_enable,
	output logic tx_busy
);

	// data bits lsb first, ones shift in behind them for the stop bit
	frame_pkg::byte_t shift_reg;
	logic [uart_pkg::BIT_TIMER_WIDTH-1:0] bit_timer;
	logic [uart_pkg::BIT_INDEX_WIDTH-1:0] bit_index;

	logic start_char;
	logic bit_end;
	logic last_bit;

	// a start pulse while a character is on the line is dropped
	assign start_char = tx_start && !tx_busy;

	assign bit_end = tx_busy &&
		(bit_timer == (uart_pkg::BIT_TIMER_WIDTH)'(uart_pkg::CLKS_PER_BIT - 1));

	assign last_bit = bit_index == (uart_pkg::BIT_INDEX_WIDTH)'(uart_pkg::BITS_PER_CHAR - 1);

	//////////////////////////////
	// bit timing and line state
	//////////////////////////////

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			tx_o <= 1'b1;
			tx_enable <= 1'b0;
			tx_busy <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
		end else if (start_char) begin
			// start bit goes out on the next clock
			tx_o <= 1'b0;
			tx_enable <= 1'b1;
			tx_busy <= 1'b1;
			bit_timer <= '0;
			bit_index <= '0;
		end else if (tx_busy) begin
			if (bit_end) begin
				bit_timer <= '0;
				if (last_bit) begin
					// release the driver once the stop bit is done
					tx_o <= 1'b1;
					tx_enable <= 1'b0;
					tx_busy <= 1'b0;
				end else begin
					tx_o <= shift_reg[0];
					bit_index <= bit_index + 1'b1;
				end
			end else begin
				bit_timer <= bit_timer + 1'b1;
			end
		end
	end

	//////////////////////////////
	// character shifter
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (start_char) begin
			shift_reg <= tx_byte;
		end else if (bit_end && !last_bit) begin
			// refill with ones so the stop bit follows the data
			shift_reg <= {1'b1, shift_reg[7:1]};
		end
	end

endmodule

// File: logic/frame_sequencer.sv
module frame_sequencer (
	input  logic CLK,
	input  logic reset,
	input  frame_pkg::motor_id_t motor_id,
	input  frame_pkg::setpoint_t setpoint,
	input  frame_pkg::crc_t crc,
	input  logic tx_busy,
	output logic crc_clear,
	output logic crc_valid,
	output frame_pkg::byte_t crc_byte,
	output logic tx_start,
	output frame_pkg::byte_t tx_byte
);

	// state[1] picks the setpoint frame, state[0] is the send phase
	// counting up walks prep status, send status, prep setpoint, send setpoint
	logic [1:0] state;
	// 0 load buffer, 1 feed crc, 2 let last byte settle, 3 store crc
	logic [1:0] prep_step;
	logic [frame_pkg::INDEX_WIDTH-1:0] buf_index;
	logic [frame_pkg::INDEX_WIDTH-1:0] frame_len;
	logic [frame_pkg::INDEX_WIDTH-1:0] crc_index;
	logic [frame_pkg::GAP_WIDTH-1:0] gap_count;
	logic [8*frame_pkg::MAGIC_LENGTH-1:0] magic;

	frame_pkg::byte_t frame_buf [frame_pkg::MAX_FRAME_LENGTH];

	logic sending;
	logic load_frame;
	logic feed_crc;
	logic store_crc;
	logic issue_byte;
	logic frame_done;

	//////////////////////////////
	// frame selection
	//////////////////////////////

	assign sending = state[0];

	assign frame_len = state[1] ?
		(frame_pkg::INDEX_WIDTH)'(frame_pkg::SETPOINT_LENGTH) :
		(frame_pkg::INDEX_WIDTH)'(frame_pkg::STATUS_REQUEST_LENGTH);

	// crc sits in the last two bytes
	assign crc_index = frame_len - (frame_pkg::INDEX_WIDTH)'(2);

	assign magic = state[1] ? frame_pkg::SETPOINT_MAGIC : frame_pkg::STATUS_REQUEST_MAGIC;

	assign load_frame = !sending && (prep_step == 2'd0);
	assign feed_crc = !sending && (prep_step == 2'd1);
	assign store_crc = !sending && (prep_step == 2'd3);

	// tx_start is still high the cycle before busy rises, so wait on both
	assign issue_byte = sending && (buf_index != frame_len) && !tx_busy && !tx_start;
	assign frame_done = sending && (buf_index == frame_len) && !tx_busy && !tx_start;

	//////////////////////////////
	// control FSM
	//////////////////////////////

	always_ff @(posedge CLK or posedge reset) begin
		if (reset) begin
			state <= 2'd0;
			prep_step <= 2'd0;
			buf_index <= '0;
			gap_count <= '0;
			crc_clear <= 1'b0;
			crc_valid <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			crc_clear <= 1'b0;
			crc_valid <= 1'b0;
			tx_start <= 1'b0;
			if (sending) begin
				if (issue_byte) begin
					tx_start <= 1'b1;
					buf_index <= buf_index + 1'b1;
				end else if (frame_done) begin
					// quiet gap counts from the end of the last stop bit
					if (gap_count == (frame_pkg::GAP_WIDTH)'(frame_pkg::GAP_CYCLES - 1)) begin
						gap_count <= '0;
						buf_index <= '0;
						state <= state + 2'd1;
					end else begin
						gap_count <= gap_count + 1'b1;
					end
				end
			end else begin
				case (prep_step)
					2'd0: begin
						crc_clear <= 1'b1;
						buf_index <= (frame_pkg::INDEX_WIDTH)'(frame_pkg::MAGIC_LENGTH);
						prep_step <= 2'd1;
					end
					2'd1: begin
						// payload runs from the id up to the crc slot
						crc_valid <= 1'b1;
						buf_index <= buf_index + 1'b1;
						if (buf_index + 1'b1 == crc_index) begin
							prep_step <= 2'd2;
						end
					end
					2'd2: begin
						prep_step <= 2'd3;
					end
					default: begin
						buf_index <= '0;
						prep_step <= 2'd0;
						state <= state + 2'd1;
					end
				endcase
			end
		end
	end

	//////////////////////////////
	// frame buffer and byte paths
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (load_frame) begin
			for (int i = 0; i < frame_pkg::MAGIC_LENGTH; i++) begin
				frame_buf[i] <= magic[8*(frame_pkg::MAGIC_LENGTH-1-i) +: 8];
			end
			frame_buf[frame_pkg::MAGIC_LENGTH] <= motor_id;
			// setpoint is taken once, on entry, high byte first
			if (state[1]) begin
				for (int i = 0; i < $bits(setpoint) / 8; i++) begin
					frame_buf[frame_pkg::MAGIC_LENGTH+1+i] <=
						setpoint[8*($bits(setpoint)/8-1-i) +: 8];
				end
			end
		end
		if (store_crc) begin
			frame_buf[crc_index] <= crc[15:8];
			frame_buf[crc_index + 1'b1] <= crc[7:0];
		end
		if (feed_crc) begin
			crc_byte <= frame_buf[buf_index];
		end
		if (issue_byte) begin
			tx_byte <= frame_buf[buf_index];
		end
	end

endmodule

// File: logic/motor_link_top.sv
module motor_link_top (
	input  logic CLK,
	input  logic reset,
	input  frame_pkg::motor_id_t motor_id,
	input  frame_pkg::setpoint_t setpoint,
	output logic tx_o,
	output logic tx_enable
);

	logic crc_clear;
	logic crc_valid;
	frame_pkg::byte_t crc_byte;
	frame_pkg::crc_t crc;

	logic tx_start;
	logic tx_busy;
	frame_pkg::byte_t tx_byte;

	// builds frames and paces them against the serializer
	frame_sequencer u_frame_sequencer (
		.CLK       (CLK),
		.reset     (reset),
		.motor_id  (motor_id),
		.setpoint  (setpoint),
		.crc       (crc),
		.tx_busy   (tx_busy),
		.crc_clear (crc_clear),
		.crc_valid (crc_valid),
		.crc_byte  (crc_byte),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte)
	);

	crc16_engine u_crc16_engine (
		.CLK       (CLK),
		.reset     (reset),
		.crc_clear (crc_clear),
		.crc_valid (crc_valid),
		.crc_byte  (crc_byte),
		.crc       (crc)
	);

	// half-duplex line, tx_enable steers the driver
	uart_tx u_uart_tx (
		.CLK       (CLK),
		.reset     (reset),
		.tx_start  (tx_start),
		.tx_byte   (tx_byte),
		.tx_o      (tx_o),
		.tx_enable (tx_enable),
		.tx_busy   (tx_busy)
	);

endmodule

// File: dv/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

//////////////////////////////
// reference crc
//////////////////////////////

// poly 8005, start at all ones, msb first, no reflection, no final xor
function automatic frame_pkg::crc_t model_crc(input frame_pkg::byte_t data [$]);
	frame_pkg::crc_t remainder;
	logic top;
	remainder = frame_pkg::CRC_INIT;
	foreach (data[n]) begin
		for (int b = 7; b >= 0; b--) begin
			top = remainder[15];
			remainder = remainder << 1;
			if (top != data[n][b]) begin
				remainder = remainder ^ frame_pkg::CRC_POLY;
			end
		end
	end
	return remainder;
endfunction

//////////////////////////////
// expected frame
//////////////////////////////

task automatic build_expected_frame(
	input bit setpoint_frame,
	input frame_pkg::motor_id_t id,
	input frame_pkg::setpoint_t value,
	output frame_pkg::byte_t frame [frame_pkg::MAX_FRAME_LENGTH],
	output int length
);
	logic [31:0] magic;
	frame_pkg::crc_t crc;
	frame_pkg::byte_t payload [$];
	magic = setpoint_frame ? frame_pkg::SETPOINT_MAGIC : frame_pkg::STATUS_REQUEST_MAGIC;
	length = setpoint_frame ? frame_pkg::SETPOINT_LENGTH : frame_pkg::STATUS_REQUEST_LENGTH;
	foreach (frame[i]) begin
		frame[i] = 8'h00;
	end
	payload.push_back(id);
	if (setpoint_frame) begin
		// setpoint high byte first
		payload.push_back(value[31:24]);
		payload.push_back(value[23:16]);
		payload.push_back(value[15:8]);
		payload.push_back(value[7:0]);
	end
	for (int i = 0; i < frame_pkg::MAGIC_LENGTH; i++) begin
		frame[i] = magic[31 - 8*i -: 8];
	end
	foreach (payload[i]) begin
		frame[frame_pkg::MAGIC_LENGTH + i] = payload[i];
	end
	crc = model_crc(payload);
	frame[length - 2] = crc[15:8];
	frame[length - 1] = crc[7:0];
endtask

//////////////////////////////
// line decoder
//////////////////////////////

// entered on the negedge where the start bit was first seen low
// walks the whole character, bit centres sit 7 negedges into each bit
task automatic receive_char(output frame_pkg::byte_t data);
	int bit_pos;
	check_level("tx_enable", tx_enable, 1'b1);
	for (int idx = 1; idx < uart_pkg::BITS_PER_CHAR * uart_pkg::CLKS_PER_BIT; idx++) begin
		@(negedge CLK);
		check_level("tx_enable", tx_enable, 1'b1);
		bit_pos = idx / uart_pkg::CLKS_PER_BIT;
		if (idx % uart_pkg::CLKS_PER_BIT == uart_pkg::CLKS_PER_BIT / 2 - 1) begin
			if (bit_pos == 0) begin
				check_level("start bit on tx_o", tx_o, 1'b0);
			end else if (bit_pos == uart_pkg::BITS_PER_CHAR - 1) begin
				check_level("stop bit on tx_o", tx_o, 1'b1);
			end else begin
				// data goes lsb first
				data[bit_pos - 1] = tx_o;
			end
		end
	end
endtask

`endif

// File: dv/tb_motor_link.sv
module tb_motor_link;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'd9;
	localparam int CLK_PERIOD = 100;
	localparam int FRAME_COUNT = 6;
	// idle clocks allowed while looking for a start bit
	localparam int START_TIMEOUT = 500;

	logic CLK;
	logic reset;
	frame_pkg::motor_id_t motor_id;
	frame_pkg::setpoint_t setpoint;
	logic tx_o;
	logic tx_enable;

	logic [31:0] rng_state;

	motor_link_top DUT (
		.CLK       (CLK),
		.reset     (reset),
		.motor_id  (motor_id),
		.setpoint  (setpoint),
		.tx_o      (tx_o),
		.tx_enable (tx_enable)
	);

	initial begin
		CLK = 1'b0;
	end

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	//////////////////////////////
	// failure and compare tasks
	//////////////////////////////

	task automatic end_in_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic fail_with(input string what);
		$display("%s (at %0t)", what, $time);
		end_in_failure();
	endtask

	task automatic check_level(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("** Error: %s got %h expected %h at %0t", name, got, expected, $time);
			end_in_failure();
		end
	endtask

	task automatic check_byte(input string name, input frame_pkg::byte_t got,
		input frame_pkg::byte_t expected);
		if (got !== expected) begin
			$display("** Error: %s got %h expected %h at %0t", name, got, expected, $time);
			end_in_failure();
		end
	endtask

	task automatic check_crc(input string name, input frame_pkg::crc_t got,
		input frame_pkg::crc_t expected);
		if (got !== expected) begin
			$display("** Error: %s got %h expected %h at %0t", name, got, expected, $time);
			end_in_failure();
		end
	endtask

	task automatic check_setpoint(input string name, input frame_pkg::setpoint_t got,
		input frame_pkg::setpoint_t expected);
		if (got !== expected) begin
			$display("** Error: %s got %h expected %h at %0t", name, got, expected, $time);
			end_in_failure();
		end
	endtask

	`include "tb_frame_model.svh"

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	// counts quiet negedges until tx_o falls, optionally driving a new setpoint
	task automatic wait_for_start(input bit new_setpoint, output int idle);
		bit found;
		logic [31:0] value;
		idle = 0;
		found = 1'b0;
		for (int cycles = 0; cycles < START_TIMEOUT && !found; cycles++) begin
			@(negedge CLK);
			if (tx_o === 1'b0) begin
				found = 1'b1;
			end else begin
				check_level("tx_o", tx_o, 1'b1);
				check_level("tx_enable", tx_enable, 1'b0);
				idle++;
				if (new_setpoint && idle == 1) begin
					@(posedge CLK);
					#5;
					draw_random(value);
					setpoint = value;
				end
			end
		end
		if (!found) begin
			fail_with("timed out waiting for a start bit on tx_o");
		end
		if (idle == 0) begin
			fail_with("tx_o went low without a falling edge");
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin : main_flow
		frame_pkg::byte_t expected [frame_pkg::MAX_FRAME_LENGTH];
		frame_pkg::byte_t rx_byte;
		frame_pkg::setpoint_t expected_setpoint;
		frame_pkg::setpoint_t rx_setpoint;
		frame_pkg::crc_t rx_crc;
		logic [31:0] value;
		bit setpoint_frame;
		int length;
		int idle;

		reset = 1'b1;
		rng_state = SEED;
		draw_random(value);
		motor_id = value[7:0];
		draw_random(value);
		setpoint = value;
		repeat (3) @(posedge CLK);
		#5;
		reset = 1'b0;

		for (int frame = 0; frame < FRAME_COUNT; frame++) begin
			// first frame is a status request, then they alternate
			setpoint_frame = (frame % 2) == 1;
			expected_setpoint = setpoint;
			build_expected_frame(setpoint_frame, motor_id, setpoint, expected, length);
			rx_setpoint = '0;
			rx_crc = '0;
			for (int b = 0; b < length; b++) begin
				wait_for_start(b == 0 && frame > 0 && !setpoint_frame, idle);
				if (b == 0 && frame > 0 && idle < frame_pkg::GAP_CYCLES) begin
					fail_with("quiet gap between frames is too short");
				end
				if (b > 0 && idle >= frame_pkg::GAP_CYCLES) begin
					fail_with("frame ended before its last byte");
				end
				receive_char(rx_byte);
				if (b < frame_pkg::MAGIC_LENGTH) begin
					check_byte("magic", rx_byte, expected[b]);
				end else if (b == frame_pkg::MAGIC_LENGTH) begin
					check_byte("motor_id", rx_byte, expected[b]);
				end else if (b >= length - 2) begin
					rx_crc = {rx_crc[7:0], rx_byte};
				end else begin
					rx_setpoint = {rx_setpoint[23:0], rx_byte};
				end
			end
			if (setpoint_frame) begin
				check_setpoint("setpoint", rx_setpoint, expected_setpoint);
			end
			check_crc("crc", rx_crc, {expected[length - 2], expected[length - 1]});
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: build.f
+incdir+dv
logic/frame_pkg.sv
logic/uart_pkg.sv
logic/crc16_engine.sv
logic/uart_tx.sv
logic/frame_sequencer.sv
logic/motor_link_top.sv
dv/tb_motor_link.sv
